// File: src/synth_pkg.sv
`default_nettype none

package synth_pkg;

	// --------------------
	// widths
	localparam int SAMPLE_W      = 16;
	localparam int PHASE_W       = 32;
	localparam int SPI_WORD_BITS = 16;
	localparam int SPI_CNT_W     = $clog2(SPI_WORD_BITS + 2);	// room for "too many" edges

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic [SPI_WORD_BITS-1:0]   pitch_t;
	typedef logic [PHASE_W-1:0]         phase_t;
	typedef logic [SAMPLE_W-1:0]        level_t;	// Q15, unsigned

	// --------------------
	// supersaw
	localparam int N_SAWS       = 8;
	localparam int PITCH_SHIFT  = 8;	// pitch word -> phase increment
	localparam int SAW_TOP_BITS = 13;	// 8 x 13 bits still fits 16 bits

	// small per-voice offsets, gives the beating
	localparam phase_t SAW_DETUNE [N_SAWS] = '{
		32'd50000, 32'd51333, 32'd52777, 32'd53077,
		32'd54577, 32'd55336, 32'd56789, 32'd57612
	};

	localparam logic [SAMPLE_W-1:0] SAW_CENTER = 16'h8000;	// unsigned sum -> signed

	// --------------------
	// envelope and vca
	localparam level_t DECAY_START = 16'h7ffc;	// just under 1.0
	localparam level_t DECAY_STEP  = 16'h0040;	// per frame
	localparam int     VCA_SHIFT   = 15;

	// --------------------
	// i2s framing
	localparam int BCK_HALF   = 4;	// clk per half bck
	localparam int DIV_W      = $clog2(BCK_HALF);
	localparam int FRAME_BITS = 32;	// 16 left + 16 right
	localparam int BIT_W      = $clog2(FRAME_BITS);

endpackage

`default_nettype wire

// File: src/spi_word_rx.sv
`timescale 1ns/1ns
`default_nettype none

// spi mode 0 slave, receive only
module spi_word_rx
	import synth_pkg::*;
(
	input  logic   clk,
	input  logic   trigger,
	input  logic   sck,
	input  logic   mosi,
	input  logic   cs,	// active low
	output pitch_t pitch,
	output logic   note_on
);

	// --------------------
	// synchronizers, [1] is the synced value, [2] one clk older
	logic [2:0] sck_sync;
	logic [1:0] mosi_sync;	// data only, no edge detect
	logic [2:0] cs_sync;

	logic sck_rise;
	logic cs_rise;
	logic cs_low;

	logic [SPI_CNT_W-1:0] bit_cnt;
	pitch_t               shreg;	// incoming bits, msb first

	assign sck_rise = sck_sync[1] & ~sck_sync[2];
	assign cs_rise  = cs_sync[1] & ~cs_sync[2];
	assign cs_low   = ~cs_sync[1];

	always_ff @(posedge clk or posedge trigger) begin
		if (trigger) begin
			sck_sync  <= '0;
			mosi_sync <= '0;
			cs_sync   <= '1;	// idle high, no false edge after reset
		end else begin
			sck_sync  <= {sck_sync[1:0], sck};
			mosi_sync <= {mosi_sync[0], mosi};
			cs_sync   <= {cs_sync[1:0], cs};
		end
	end

	// --------------------
	// bit counter, saturates one past a full word
	always_ff @(posedge clk or posedge trigger) begin
		if (trigger) begin
			bit_cnt <= '0;
		end else if (!cs_low) begin
			bit_cnt <= '0;	// also clears on the cs_rise cycle
		end else if (sck_rise && bit_cnt <= SPI_CNT_W'(SPI_WORD_BITS)) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (sck_rise && cs_low)
			shreg <= {shreg[SPI_WORD_BITS-2:0], mosi_sync[1]};
	end

	// --------------------
	// word done, only exact length counts
	always_ff @(posedge clk or posedge trigger) begin
		if (trigger) begin
			pitch   <= '0;
			note_on <= 1'b0;
		end else begin
			note_on <= 1'b0;
			if (cs_rise && bit_cnt == SPI_CNT_W'(SPI_WORD_BITS)) begin
				pitch   <= shreg;
				note_on <= 1'b1;	// one clk pulse
			end
		end
	end

endmodule

`default_nettype wire

// File: src/supersaw_osc.sv
`timescale 1ns/1ns
`default_nettype none

// eight detuned ramps, summed
module supersaw_osc
	import synth_pkg::*;
(
	input  logic    clk,
	input  logic    trigger,
	input  logic    frame_tick,
	input  pitch_t  pitch,
	output sample_t saw
);

	phase_t acc [N_SAWS];
	phase_t inc;	// shared part of every step
	logic   tick_d;	// new acc values ready

	logic [SAMPLE_W-1:0] saw_sum;

	assign inc = phase_t'(pitch) << PITCH_SHIFT;

	// --------------------
	// phase accumulators
	always_ff @(posedge clk or posedge trigger) begin
		if (trigger) begin
			for (int i = 0; i < N_SAWS; i++)
				acc[i] <= '0;
		end else if (frame_tick) begin
			for (int i = 0; i < N_SAWS; i++)
				acc[i] <= acc[i] + inc + SAW_DETUNE[i];	// wraps, that's the ramp
		end
	end

	// top bits of each ramp, unsigned sum
	always_comb begin
		saw_sum = '0;
		for (int i = 0; i < N_SAWS; i++)
			saw_sum = saw_sum + SAMPLE_W'(acc[i][PHASE_W-1 -: SAW_TOP_BITS]);
	end

	// --------------------
	// output register, one clk after the tick
	always_ff @(posedge clk or posedge trigger) begin
		if (trigger) begin
			tick_d <= 1'b0;
			saw    <= '0;
		end else begin
			tick_d <= frame_tick;
			if (tick_d)
				saw <= sample_t'(saw_sum - SAW_CENTER);	// center on zero
		end
	end

endmodule

`default_nettype wire

// File: src/decay_vca.sv
`timescale 1ns/1ns
`default_nettype none

// linear decay envelope + vca
module decay_vca
	import synth_pkg::*;
(
	input  logic    clk,
	input  logic    trigger,
	input  logic    frame_tick,
	input  logic    note_on,
	input  sample_t saw,
	output sample_t vca_out
);

	level_t level;
	logic   note_pend;	// note waits for the next frame

	logic [2:0] tick_pipe;	// tick delayed by 1, 2, 3 clk

	logic signed [2*SAMPLE_W:0] prod;	// 16 x 17 signed

	// --------------------
	// envelope, steps once per frame
	always_ff @(posedge clk or posedge trigger) begin
		if (trigger) begin
			level     <= '0;
			note_pend <= 1'b0;
		end else begin
			if (frame_tick) begin
				note_pend <= note_on;	// a note on the tick itself waits a frame
				if (note_pend)
					level <= DECAY_START;
				else if (level > DECAY_STEP)
					level <= level - DECAY_STEP;
				else
					level <= '0;	// floor, no wrap
			end else if (note_on) begin
				note_pend <= 1'b1;
			end
		end
	end

	// --------------------
	// stage timing follows the saw register
	always_ff @(posedge clk or posedge trigger) begin
		if (trigger)
			tick_pipe <= '0;
		else
			tick_pipe <= {tick_pipe[1:0], frame_tick};
	end

	// stage 1 at tick+2, saw is new by then
	always_ff @(posedge clk) begin
		if (tick_pipe[1])
			prod <= saw * $signed({1'b0, level});	// level zero-extended
	end

	// stage 2 at tick+3, back to Q0
	always_ff @(posedge clk or posedge trigger) begin
		if (trigger)
			vca_out <= '0;
		else if (tick_pipe[2])
			vca_out <= sample_t'(prod >>> VCA_SHIFT);
	end

endmodule

`default_nettype wire

// File: src/i2s_tx.sv
`timescale 1ns/1ns
`default_nettype none

// pcm5102 style serializer, left on lrck low
module i2s_tx
	import synth_pkg::*;
(
	input  logic    clk,
	input  logic    trigger,
	input  sample_t left,
	input  sample_t right,
	output logic    frame_tick,
	output logic    bck,
	output logic    lrck,
	output logic    din
);

	logic [DIV_W-1:0] div;		// clk per half bck
	logic [BIT_W-1:0] bit_cnt;	// bit now on din
	logic [BIT_W-1:0] next_bit;
	logic             first_fall;	// first clk after reset acts as a falling edge

	logic half_end;
	logic fall;
	logic rise;
	logic frame_end;

	logic [2*SAMPLE_W-1:0] shreg;	// rest of the pair, msb first

	assign half_end  = div == DIV_W'(BCK_HALF - 1);
	assign fall      = half_end && (bck || first_fall);
	assign rise      = half_end && !bck && !first_fall;
	assign next_bit  = bit_cnt + 1'b1;	// wraps 31 -> 0
	assign frame_end = bit_cnt == BIT_W'(FRAME_BITS - 1);

	// --------------------
	// bit clock and framing
	always_ff @(posedge clk or posedge trigger) begin
		if (trigger) begin
			div        <= DIV_W'(BCK_HALF - 1);
			bit_cnt    <= BIT_W'(FRAME_BITS - 1);	// so the first fall starts frame 0
			first_fall <= 1'b1;
			bck        <= 1'b0;
			lrck       <= 1'b0;
			din        <= 1'b0;
			frame_tick <= 1'b0;
		end else begin
			frame_tick <= 1'b0;
			if (half_end)
				div <= '0;
			else
				div <= div + 1'b1;

			if (rise)
				bck <= 1'b1;	// din sampled by the dac here

			if (fall) begin
				bck        <= 1'b0;
				first_fall <= 1'b0;
				bit_cnt    <= next_bit;
				lrck       <= next_bit[BIT_W-1];	// high for the right half
				if (frame_end) begin
					din        <= left[SAMPLE_W-1];	// msb straight from the input
					frame_tick <= 1'b1;	// voice steps now
				end else begin
					din <= shreg[2*SAMPLE_W-1];
				end
			end
		end
	end

	// --------------------
	// sample latch and shifter
	always_ff @(posedge clk) begin
		if (fall) begin
			if (frame_end)
				shreg <= {left[SAMPLE_W-2:0], right, 1'b0};	// left msb already out
			else
				shreg <= {shreg[2*SAMPLE_W-2:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

// File: src/synth_top.sv
`timescale 1ns/1ns
`default_nettype none

// single voice supersaw, spi in, i2s out
module synth_top
	import synth_pkg::*;
(
	input  logic clk,
	input  logic trigger,
	input  logic sck,
	input  logic mosi,
	input  logic cs,
	output logic i2s_bck,
	output logic i2s_lrck,
	output logic i2s_din
);

	pitch_t  pitch;
	logic    note_on;
	logic    frame_tick;	// one per audio frame, from the serializer
	sample_t saw;
	sample_t vca_out;

	// --------------------
	// decode
	spi_word_rx i_rx (
		.clk     (clk),
		.trigger (trigger),
		.sck     (sck),
		.mosi    (mosi),
		.cs      (cs),
		.pitch   (pitch),
		.note_on (note_on)
	);

	// --------------------
	// execute
	supersaw_osc i_osc (
		.clk        (clk),
		.trigger    (trigger),
		.frame_tick (frame_tick),
		.pitch      (pitch),
		.saw        (saw)
	);

	decay_vca i_vca (
		.clk        (clk),
		.trigger    (trigger),
		.frame_tick (frame_tick),
		.note_on    (note_on),
		.saw        (saw),
		.vca_out    (vca_out)
	);

	// --------------------
	// result, wet left and dry right
	i2s_tx i_i2s (
		.clk        (clk),
		.trigger    (trigger),
		.left       (vca_out),
		.right      (saw),
		.frame_tick (frame_tick),
		.bck        (i2s_bck),
		.lrck       (i2s_lrck),
		.din        (i2s_din)
	);

endmodule

`default_nettype wire

// File: verif/synth_properties.sv
`timescale 1ns/1ns
`default_nettype none

// i2s framing and strobe rules, bound into synth_top
module synth_properties (
	input logic clk,
	input logic trigger,
	input logic i2s_bck,
	input logic i2s_lrck,
	input logic i2s_din,
	input logic note_on,
	input logic frame_tick
);

	logic [8:0] since_tick;	// clk since the last tick
	logic       seen_tick;

	always_ff @(posedge clk or posedge trigger) begin
		if (trigger) begin
			since_tick <= '0;
			seen_tick  <= 1'b0;
		end else if (frame_tick) begin
			since_tick <= 9'd1;
			seen_tick  <= 1'b1;
		end else if (since_tick != '1) begin
			since_tick <= since_tick + 1'b1;	// saturates
		end
	end

	// --------------------
	a_lrck_on_fall: assert property (@(posedge clk) disable iff (trigger)
		$changed(i2s_lrck) |-> $fell(i2s_bck))
		else $error("lrck moved away from a bck falling edge");

	a_din_stable: assert property (@(posedge clk) disable iff (trigger)
		i2s_bck |-> $stable(i2s_din))
		else $error("din changed while bck was high");

	a_note_pulse: assert property (@(posedge clk) disable iff (trigger)
		note_on |=> !note_on)
		else $error("note_on longer than one clk");

	a_tick_period: assert property (@(posedge clk) disable iff (trigger)
		frame_tick && seen_tick |-> since_tick == 9'd256)
		else $error("frame_tick spacing is not 256 clk");

	a_tick_missing: assert property (@(posedge clk) disable iff (trigger)
		seen_tick |-> since_tick <= 9'd256)
		else $error("frame_tick missing");

endmodule

bind synth_top synth_properties i_props (
	.clk        (clk),
	.trigger    (trigger),
	.i2s_bck    (i2s_bck),
	.i2s_lrck   (i2s_lrck),
	.i2s_din    (i2s_din),
	.note_on    (note_on),
	.frame_tick (frame_tick)
);

`default_nettype wire

// File: verif/tb_synth.sv
`timescale 1ns/1ns
`default_nettype none

module tb_synth
	import synth_pkg::*;
;

	// idle, first note, restart, then the full decay to zero plus margin
	localparam int FRAME_CLKS  = FRAME_BITS * 2 * BCK_HALF;
	localparam int DECAY_FRMS  = int'(DECAY_START) / int'(DECAY_STEP) + 1;
	localparam int TEST_FRAMES = 4 + 40 + DECAY_FRMS + 8;
	localparam int TIMEOUT_CYC = (TEST_FRAMES + 16) * FRAME_CLKS;

	logic clk = 1'b0;
	logic trigger;
	logic sck;
	logic mosi;
	logic cs;
	logic i2s_bck;
	logic i2s_lrck;
	logic i2s_din;

	integer seed;
	int     cycles = 0;

	// reference state, one voice
	logic [31:0] m_acc [N_SAWS];
	logic [15:0] m_level = '0;
	logic        m_pend = 1'b0;
	logic [15:0] tb_pitch = '0;	// pitch in effect at the next tick

	// deserializer and compare
	int          bit_idx = 0;
	int          frame_cnt = 0;
	int          frames_checked = 0;
	logic [31:0] rx_word = '0;
	logic [31:0] next_pair = '0;	// frame 0 carries zeros
	logic [31:0] got_pair;
	logic [31:0] exp_pair;
	logic [31:0] exp_q [$];
	logic [31:0] got_q [$];

	synth_top i_dut (
		.clk      (clk),
		.trigger  (trigger),
		.sck      (sck),
		.mosi     (mosi),
		.cs       (cs),
		.i2s_bck  (i2s_bck),
		.i2s_lrck (i2s_lrck),
		.i2s_din  (i2s_din)
	);

	always #5 clk = ~clk;

	// --------------------
	// helpers
	task automatic compare_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			$display(">>> FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// one voice step at a frame start, returns {left, right}
	function automatic logic [31:0] model_step(input logic [15:0] p);
		logic [15:0]        sum;
		logic signed [15:0] dry;
		logic [15:0]        wet_q0;
		int                 wet;
		sum = '0;
		for (int i = 0; i < N_SAWS; i++) begin
			m_acc[i] = m_acc[i] + (32'(p) << PITCH_SHIFT) + SAW_DETUNE[i];
			sum = sum + 16'(m_acc[i] >> (PHASE_W - SAW_TOP_BITS));	// top bits only
		end
		dry = sum - SAW_CENTER;
		if (m_pend)
			m_level = DECAY_START;	// note restarts the envelope
		else if (m_level > DECAY_STEP)
			m_level = m_level - DECAY_STEP;
		else
			m_level = '0;
		m_pend = 1'b0;
		wet = int'(dry) * int'(m_level);	// level is unsigned Q15
		wet_q0 = 16'(wet >>> VCA_SHIFT);
		return {wet_q0, dry};
	endfunction

	// mode 0, msb first, sck period 8 clk
	task automatic spi_send(input logic [15:0] word, input int nbits);
		@(negedge clk);
		cs = 1'b0;
		repeat (4) @(negedge clk);
		for (int b = 15; b > 15 - nbits; b--) begin
			mosi = word[b];
			sck = 1'b0;
			repeat (4) @(negedge clk);
			sck = 1'b1;	// sampled on this rise
			repeat (4) @(negedge clk);
		end
		sck = 1'b0;
		repeat (4) @(negedge clk);
		cs = 1'b1;
		repeat (8) @(negedge clk);	// note_on lands 3 clk after cs rises
		if (nbits == SPI_WORD_BITS) begin
			tb_pitch = word;
			m_pend = 1'b1;
		end
	endtask

	task automatic wait_frames(input int n);
		int target;
		target = frame_cnt + n;
		wait (frame_cnt >= target);
	endtask

	// --------------------
	// i2s deserializer, frame start steps the model
	always @(posedge i2s_bck) begin
		compare_value("i2s_lrck", 16'(i2s_lrck), 16'(bit_idx >= FRAME_BITS / 2));
		if (bit_idx == 0) begin
			exp_q.push_back(next_pair);	// frame j holds sample j-1
			next_pair = model_step(tb_pitch);
			frame_cnt = frame_cnt + 1;
		end
		rx_word = {rx_word[30:0], i2s_din};
		if (bit_idx == FRAME_BITS - 1) begin
			got_q.push_back(rx_word);
			bit_idx = 0;
		end else begin
			bit_idx = bit_idx + 1;
		end
	end

	// compare, away from the bck edges
	always @(negedge clk) begin
		if (got_q.size() != 0) begin
			got_pair = got_q.pop_front();
			exp_pair = exp_q.pop_front();
			compare_value("left sample", got_pair[31:16], exp_pair[31:16]);
			compare_value("right sample", got_pair[15:0], exp_pair[15:0]);
			frames_checked = frames_checked + 1;
		end
	end

	// hang guard
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYC) begin
			$display("Error: timeout after %0d cycles, test did not finish", cycles);
			$display(">>> FAIL");
			$fatal(1, "timeout");
		end
	end

	// --------------------
	// stimulus
	initial begin
		for (int i = 0; i < N_SAWS; i++)
			m_acc[i] = '0;
		seed = 32'h8cae;
		trigger = 1'b1;
		sck = 1'b0;
		mosi = 1'b0;
		cs = 1'b1;
		repeat (2) @(negedge clk);
		trigger = 1'b0;

		wait_frames(4);	// dry saw at pitch 0, left silent
		spi_send(16'($random(seed)), SPI_WORD_BITS);	// new pitch plus note
		wait_frames(40);
		spi_send(16'($random(seed)), SPI_WORD_BITS);	// restart mid decay
		wait_frames(20);
		spi_send(16'($random(seed)), 12);	// cut short, ignored
		while (m_level != '0)
			wait_frames(1);
		wait_frames(4);	// zero level reaches the output

		if (frames_checked >= TEST_FRAMES / 2) begin
			$display(">>> PASS");
			$finish;
		end else begin
			$display("Error: only %0d frames were compared", frames_checked);
			$display(">>> FAIL");
			$fatal(1, "too few frames");
		end
	end

endmodule

`default_nettype wire

// File: vlog.f
src/synth_pkg.sv
src/spi_word_rx.sv
src/supersaw_osc.sv
src/decay_vca.sv
src/i2s_tx.sv
src/synth_top.sv
verif/synth_properties.sv
verif/tb_synth.sv

// File: Makefile
# Verilator build and run of the synth testbench

TOP = tb_synth

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): vlog.f $(wildcard src/*.sv verif/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f

run: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) | tee sim.log
	@grep -q ">>> PASS" sim.log
	@! grep -q ">>> FAIL" sim.log

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f vlog.f
	verilator --lint-only -Wall -f vlog.f --top-module synth_top

clean:
	rm -rf obj_dir sim.log
